// ==== verilog/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 32;
   localparam int MEM_WORDS  = 1024;
   localparam int BOOT_WORDS = 256;
   localparam int WORD_W     = $clog2(MEM_WORDS);

   localparam int N_SLAVES   = 2;
   localparam int SLAVE_W    = $clog2(N_SLAVES);
   localparam int UART_SLAVE = 0;
   localparam int RST_SLAVE  = 1;

   typedef logic [DATA_W-1:0] data_t;

   // sram view of the address
   typedef struct packed {
      logic                       is_periph;
      logic [ADDR_W-WORD_W-4:0]   unused;
      logic [WORD_W-1:0]          word;
      logic [1:0]                 offset;
   } mem_addr_t;

   // peripheral view, 8 registers per slave
   typedef struct packed {
      logic                       is_periph;
      logic [SLAVE_W-1:0]         slave;
      logic [ADDR_W-SLAVE_W-7:0]  unused;
      logic [2:0]                 reg_idx;
      logic [1:0]                 offset;
   } periph_addr_t;

   typedef union packed {
      mem_addr_t    mem;
      periph_addr_t periph;
   } addr_t;

   typedef struct packed {
      logic       valid;
      addr_t      addr;
      data_t      wdata;
      logic [3:0] wstrb;
   } bus_req_t;

   typedef struct packed {
      logic  ready;
      data_t rdata;
   } bus_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

   // register indices inside the uart slave
   localparam logic [2:0] UART_TXDATA = 3'd0;
   localparam logic [2:0] UART_STATUS = 3'd1;
   localparam logic [2:0] UART_RXDATA = 3'd2;
   localparam logic [2:0] UART_DIV    = 3'd3;

   // clock cycles per bit after reset
   localparam logic [15:0] UART_DIV_RST = 16'd16;

   typedef logic [7:0] uart_byte_t;

   typedef struct packed {
      logic        tx_start;
      uart_byte_t  tx_byte;
      logic [15:0] div;
      logic        rx_take;
   } uart_ctl_t;

endpackage

`default_nettype wire

// ==== verilog/int_mem.sv ====
`default_nettype none
`timescale 1ns/1ps

module int_mem import soc_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     boot,
   input  bus_req_t req,
   output bus_rsp_t rsp
);

   data_t             mem [MEM_WORDS];
   logic [WORD_W-1:0] idx;
   logic              ready_q;
   data_t             rdata_q;
   logic              fire;
   logic              wr_ok;

   // ready low for one cycle after each pulse
   assign fire = req.valid & ~ready_q;
   assign idx  = req.addr.mem.word;

   // boot region is locked once boot drops
   assign wr_ok = (|req.wstrb) && (boot || (idx >= BOOT_WORDS));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= fire;
      end
   end

   always_ff @(posedge clk) begin
      if (fire && wr_ok) begin
         for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
               mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
      if (fire) begin
         rdata_q <= mem[idx];
      end
   end

   assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== verilog/periph_intercon.sv ====
`default_nettype none
`timescale 1ns/1ps

module periph_intercon import soc_pkg::*; (
   input  bus_req_t            req,
   output bus_rsp_t            rsp,
   output logic [N_SLAVES-1:0] slave_valid,
   input  bus_rsp_t            slave_rsp [N_SLAVES]
);

   logic [SLAVE_W-1:0] sel;

   assign sel = req.addr.periph.slave;

   // one-hot valid towards the addressed slave
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         slave_valid[i] = req.valid && (sel == i);
      end
   end

   // return path follows the same index
   assign rsp = slave_rsp[sel];

endmodule

`default_nettype wire

// ==== verilog/uart_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_regs import soc_pkg::*, uart_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       valid,
   input  bus_req_t   req,
   output bus_rsp_t   rsp,
   output uart_ctl_t  ctl,
   input  logic       tx_busy,
   input  logic       rx_valid,
   input  uart_byte_t rx_byte
);

   logic        ready_q;
   data_t       rdata_q;
   logic        fire;
   logic        write;
   logic [2:0]  idx;
   logic        tx_start_q;
   logic        rx_take_q;
   uart_byte_t  tx_byte_q;
   logic [15:0] div_q;

   assign fire  = valid & ~ready_q;
   assign write = |req.wstrb;
   assign idx   = req.addr.periph.reg_idx;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q    <= 1'b0;
         tx_start_q <= 1'b0;
         rx_take_q  <= 1'b0;
         div_q      <= UART_DIV_RST;
      end else begin
         ready_q    <= fire;
         // a busy transmitter drops the write
         tx_start_q <= fire && write && (idx == UART_TXDATA) && !tx_busy;
         rx_take_q  <= fire && !write && (idx == UART_RXDATA);
         if (fire && write && (idx == UART_DIV)) begin
            div_q <= req.wdata[15:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire && write && (idx == UART_TXDATA)) begin
         tx_byte_q <= req.wdata[7:0];
      end
      if (fire) begin
         case (idx)
            UART_STATUS: rdata_q <= data_t'({rx_valid, tx_busy});
            UART_RXDATA: rdata_q <= data_t'(rx_byte);
            UART_DIV:    rdata_q <= data_t'(div_q);
            default:     rdata_q <= '0;
         endcase
      end
   end

   assign rsp = '{ready: ready_q, rdata: rdata_q};
   assign ctl = '{tx_start: tx_start_q, tx_byte: tx_byte_q, div: div_q, rx_take: rx_take_q};

endmodule

`default_nettype wire

// ==== verilog/uart_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_core import uart_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  uart_ctl_t  ctl,
   output logic       tx_busy,
   output logic       rx_valid,
   output uart_byte_t rx_byte,
   output logic       txd,
   input  logic       rxd,
   output logic       rts,
   input  logic       cts
);

   typedef enum logic [1:0] {TX_IDLE, TX_WAIT, TX_SEND} tx_state_t;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   tx_state_t   tx_state;
   logic [9:0]  tx_sh;
   logic [15:0] tx_cnt;
   logic [3:0]  tx_bits;
   logic [1:0]  cts_sync;

   rx_state_t   rx_state;
   uart_byte_t  rx_sh;
   logic [15:0] rx_cnt;
   logic [2:0]  rx_bits;
   logic [1:0]  rxd_sync;
   logic        rx_shift;
   logic        rx_done;

   logic [15:0] bit_last;
   logic [15:0] bit_half;

   assign bit_last = ctl.div - 16'd1;
   assign bit_half = {1'b0, ctl.div[15:1]};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cts_sync <= 2'b11;
         rxd_sync <= 2'b11;
      end else begin
         cts_sync <= {cts_sync[0], cts};
         rxd_sync <= {rxd_sync[0], rxd};
      end
   end

   // transmitter, stop bit shifted in from the top
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_state <= TX_IDLE;
         tx_sh    <= '1;
         tx_cnt   <= '0;
         tx_bits  <= '0;
      end else begin
         case (tx_state)
            TX_IDLE: begin
               if (ctl.tx_start) begin
                  tx_sh    <= {1'b1, ctl.tx_byte, 1'b0};
                  tx_state <= TX_WAIT;
               end
            end
            TX_WAIT: begin
               // frame waits while cts is high
               if (!cts_sync[1]) begin
                  tx_cnt   <= '0;
                  tx_bits  <= '0;
                  tx_state <= TX_SEND;
               end
            end
            default: begin
               if (tx_cnt == bit_last) begin
                  tx_cnt <= '0;
                  tx_sh  <= {1'b1, tx_sh[9:1]};
                  if (tx_bits == 4'd9) begin
                     tx_state <= TX_IDLE;
                  end else begin
                     tx_bits <= tx_bits + 4'd1;
                  end
               end else begin
                  tx_cnt <= tx_cnt + 16'd1;
               end
            end
         endcase
      end
   end

   assign tx_busy = (tx_state != TX_IDLE);
   assign txd     = (tx_state == TX_SEND) ? tx_sh[0] : 1'b1;

   // receiver samples mid bit
   assign rx_shift = (rx_state == RX_DATA) && (rx_cnt == bit_last);
   assign rx_done  = (rx_state == RX_STOP) && (rx_cnt == bit_last) && rxd_sync[1];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_bits  <= '0;
         rx_valid <= 1'b0;
      end else begin
         case (rx_state)
            RX_IDLE: begin
               if (!rxd_sync[1]) begin
                  rx_cnt   <= '0;
                  rx_state <= RX_START;
               end
            end
            RX_START: begin
               if (rx_cnt == bit_half) begin
                  rx_cnt   <= '0;
                  rx_bits  <= '0;
                  // short glitch, back to idle
                  rx_state <= rxd_sync[1] ? RX_IDLE : RX_DATA;
               end else begin
                  rx_cnt <= rx_cnt + 16'd1;
               end
            end
            RX_DATA: begin
               if (rx_cnt == bit_last) begin
                  rx_cnt <= '0;
                  if (rx_bits == 3'd7) begin
                     rx_state <= RX_STOP;
                  end else begin
                     rx_bits <= rx_bits + 3'd1;
                  end
               end else begin
                  rx_cnt <= rx_cnt + 16'd1;
               end
            end
            default: begin
               if (rx_cnt == bit_last) begin
                  rx_cnt   <= '0;
                  rx_state <= RX_IDLE;
               end else begin
                  rx_cnt <= rx_cnt + 16'd1;
               end
            end
         endcase
         // new byte wins over a take in the same cycle
         if (rx_done) begin
            rx_valid <= 1'b1;
         end else if (ctl.rx_take) begin
            rx_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_shift) begin
         rx_sh <= {rxd_sync[1], rx_sh[7:1]};
      end
      if (rx_done) begin
         rx_byte <= rx_sh;
      end
   end

   assign rts = ~rx_valid;

endmodule

`default_nettype wire

// ==== verilog/rst_ctr.sv ====
`default_nettype none
`timescale 1ns/1ps

module rst_ctr import soc_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     valid,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     soft_rst,
   output logic     boot
);

   logic  ready_q;
   data_t rdata_q;
   logic  fire;
   logic  rst_req;

   assign fire = valid & ~ready_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q  <= 1'b0;
         rst_req  <= 1'b0;
         soft_rst <= 1'b0;
         boot     <= 1'b1;
      end else begin
         ready_q  <= fire;
         rst_req  <= fire && (|req.wstrb) && req.wdata[0];
         // pulse lands the cycle after ready
         soft_rst <= rst_req;
         if (rst_req) begin
            boot <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         rdata_q <= data_t'(boot);
      end
   end

   assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== verilog/system.sv ====
`default_nettype none
`timescale 1ns/1ps

module system import soc_pkg::*, uart_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     uart_txd,
   input  logic     uart_rxd,
   output logic     uart_rts,
   input  logic     uart_cts
);

   logic                sys_rst_n;
   logic                soft_rst;
   logic                boot;

   bus_req_t            mem_req;
   bus_req_t            per_req;
   bus_rsp_t            mem_rsp;
   bus_rsp_t            per_rsp;
   logic [N_SLAVES-1:0] slave_valid;
   bus_rsp_t            slave_rsp [N_SLAVES];

   uart_ctl_t           uart_ctl;
   logic                tx_busy;
   logic                rx_valid;
   uart_byte_t          rx_byte;

   // soft reset comes straight from a flop in rst_ctr
   assign sys_rst_n = arst_n & ~soft_rst;

   // bit 15 picks sram or peripherals
   always_comb begin
      mem_req       = req;
      per_req       = req;
      mem_req.valid = req.valid & ~req.addr.mem.is_periph;
      per_req.valid = req.valid & req.addr.mem.is_periph;
      rsp           = req.addr.mem.is_periph ? per_rsp : mem_rsp;
   end

   int_mem int_mem0 (
      .clk    (clk),
      .arst_n (sys_rst_n),
      .boot   (boot),
      .req    (mem_req),
      .rsp    (mem_rsp)
   );

   periph_intercon intercon (
      .req         (per_req),
      .rsp         (per_rsp),
      .slave_valid (slave_valid),
      .slave_rsp   (slave_rsp)
   );

   uart_regs uart_regs0 (
      .clk      (clk),
      .arst_n   (sys_rst_n),
      .valid    (slave_valid[UART_SLAVE]),
      .req      (per_req),
      .rsp      (slave_rsp[UART_SLAVE]),
      .ctl      (uart_ctl),
      .tx_busy  (tx_busy),
      .rx_valid (rx_valid),
      .rx_byte  (rx_byte)
   );

   uart_core uart_core0 (
      .clk      (clk),
      .arst_n   (sys_rst_n),
      .ctl      (uart_ctl),
      .tx_busy  (tx_busy),
      .rx_valid (rx_valid),
      .rx_byte  (rx_byte),
      .txd      (uart_txd),
      .rxd      (uart_rxd),
      .rts      (uart_rts),
      .cts      (uart_cts)
   );

   // only the external reset clears the controller
   rst_ctr rst_ctr0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .valid    (slave_valid[RST_SLAVE]),
      .req      (per_req),
      .rsp      (slave_rsp[RST_SLAVE]),
      .soft_rst (soft_rst),
      .boot     (boot)
   );

endmodule

`default_nettype wire

// ==== bench/tb_system.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_system import soc_pkg::*, uart_pkg::*; ();

   localparam int          CLK_NS    = 8;
   localparam logic [31:0] SEED      = 32'hebe3_923e;
   localparam int          N_MEM     = 16;
   localparam int          N_BOOT    = 6;
   localparam int          N_BYTES   = 6;
   localparam int          DIV_MIN   = 6;
   localparam int          DIV_MAX   = 12;
   localparam int          BUS_LIMIT = 8;
   localparam int          POLL_MAX  = 10 * DIV_MAX;

   // two extra frames for the cts hold, one for the held byte
   localparam int UART_CYCLES  = (N_BYTES + 3) * 10 * DIV_MAX;
   localparam int BUS_ACCESSES = 3 * N_MEM + 5 * N_BOOT + 10 * N_BYTES + 20;
   localparam int MARGIN       = 4000;
   localparam int WATCHDOG_NS  = (UART_CYCLES + 2 * BUS_ACCESSES + MARGIN) * CLK_NS;

   logic     clk;
   logic     arst_n;
   bus_req_t req;
   bus_rsp_t rsp;
   logic     uart_txd;
   logic     uart_rxd;
   logic     uart_rts;
   logic     uart_cts;

   data_t shadow [MEM_WORDS];
   int    mem_idx [N_MEM];
   int    boot_idx [N_BOOT];
   logic  boot_model;
   int    errors;
   int    checks;
   int    test_errors;

   system uut (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (req),
      .rsp      (rsp),
      .uart_txd (uart_txd),
      .uart_rxd (uart_rxd),
      .uart_rts (uart_rts),
      .uart_cts (uart_cts)
   );

   // serial loopback
   assign uart_rxd = uart_txd;

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

   // expected sram word after a write, byte lanes and boot lock applied
   function automatic data_t ref_word(input data_t old, input data_t wdata,
                                      input logic [3:0] wstrb, input int idx,
                                      input logic boot_on);
      data_t res;
      res = old;
      if (boot_on || idx >= BOOT_WORDS) begin
         for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
               res[8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
      return res;
   endfunction

   function automatic addr_t mem_addr(input int idx);
      addr_t a;
      a = '0;
      a.mem.word = idx[WORD_W-1:0];
      return a;
   endfunction

   function automatic addr_t periph_addr(input int slave, input logic [2:0] reg_idx);
      addr_t a;
      a = '0;
      a.periph.is_periph = 1'b1;
      a.periph.slave     = slave[SLAVE_W-1:0];
      a.periph.reg_idx   = reg_idx;
      return a;
   endfunction

   task automatic check_word(input string name, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_byte(input string name, input uart_byte_t got,
                             input uart_byte_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%02h expected 0x%02h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%01h expected 0x%01h", name, got, exp);
      end
   endtask

   // one access, held until the ready pulse
   task automatic bus_access(input addr_t addr, input data_t wdata,
                             input logic [3:0] wstrb, output data_t rdata);
      bus_req_t r;
      int       waited;
      r      = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      rdata  = '0;
      waited = 0;
      @(posedge clk);
      req <= r;
      do begin
         @(posedge clk);
         waited++;
      end while (!rsp.ready && waited < BUS_LIMIT);
      if (!rsp.ready) begin
         errors++;
         $display("bus access to 0x%04h got no ready within %0d cycles", addr, BUS_LIMIT);
      end else begin
         rdata = rsp.rdata;
         if (waited != 2) begin
            errors++;
            $display("bus access to 0x%04h was served after %0d cycles", addr, waited);
         end
      end
      req <= '0;
   endtask

   task automatic mem_write(input int idx, input data_t d, input logic [3:0] s);
      data_t rd;
      bus_access(mem_addr(idx), d, s, rd);
      shadow[idx] = ref_word(shadow[idx], d, s, idx, boot_model);
   endtask

   task automatic mem_check(input int idx);
      data_t rd;
      bus_access(mem_addr(idx), '0, 4'h0, rd);
      check_word($sformatf("mem[%0d]", idx), rd, shadow[idx]);
   endtask

   task automatic wait_status(input int bit_pos, input logic value);
      data_t st;
      int    polls;
      polls = 0;
      do begin
         bus_access(periph_addr(UART_SLAVE, UART_STATUS), '0, 4'h0, st);
         polls++;
      end while (st[bit_pos] !== value && polls < POLL_MAX);
      if (st[bit_pos] !== value) begin
         errors++;
         $display("uart status bit %0d never became %0b", bit_pos, value);
      end
   endtask

   task automatic finish_test(input int num, input string name);
      $display("test %0d %s: %s", num, name, (errors == test_errors) ? "ok" : "FAILED");
      test_errors = errors;
   endtask

   initial begin
      data_t      rd;
      int         div;
      uart_byte_t tx_b;
      logic       txd_low;

      void'($urandom(SEED));
      arst_n     <= 1'b0;
      req        <= '0;
      uart_cts   <= 1'b0;
      boot_model = 1'b1;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      for (int i = 0; i < N_MEM; i++) begin
         mem_idx[i] = $urandom_range(MEM_WORDS - 1, BOOT_WORDS);
         mem_write(mem_idx[i], data_t'($urandom), 4'hf);
      end
      for (int i = 0; i < N_MEM; i++) begin
         mem_write(mem_idx[i], data_t'($urandom), 4'($urandom_range(15, 1)));
      end
      for (int i = 0; i < N_MEM; i++) begin
         mem_check(mem_idx[i]);
      end
      finish_test(1, "sram random strobes");

      for (int i = 0; i < N_BOOT; i++) begin
         boot_idx[i] = $urandom_range(BOOT_WORDS - 1, 0);
         mem_write(boot_idx[i], data_t'($urandom), 4'hf);
         mem_write(boot_idx[i], data_t'($urandom), 4'($urandom_range(15, 1)));
      end
      for (int i = 0; i < N_BOOT; i++) begin
         mem_check(boot_idx[i]);
      end
      finish_test(2, "boot region open");

      bus_access(periph_addr(RST_SLAVE, 3'd0), '0, 4'h0, rd);
      check_word("boot", rd, 32'h1);
      bus_access(periph_addr(RST_SLAVE, 3'd0), 32'h1, 4'hf, rd);
      boot_model = 1'b0;
      repeat (3) @(posedge clk);
      bus_access(periph_addr(RST_SLAVE, 3'd0), '0, 4'h0, rd);
      check_word("boot", rd, 32'h0);
      for (int i = 0; i < N_BOOT; i++) begin
         mem_check(boot_idx[i]);
      end
      finish_test(3, "soft reset");

      for (int i = 0; i < N_BOOT; i++) begin
         mem_write(boot_idx[i], data_t'($urandom), 4'($urandom_range(15, 1)));
      end
      for (int i = 0; i < N_MEM; i++) begin
         mem_write(mem_idx[i], data_t'($urandom), 4'($urandom_range(15, 1)));
      end
      for (int i = 0; i < N_BOOT; i++) begin
         mem_check(boot_idx[i]);
      end
      for (int i = 0; i < N_MEM; i++) begin
         mem_check(mem_idx[i]);
      end
      finish_test(4, "boot region locked");

      div = $urandom_range(DIV_MAX, DIV_MIN);
      bus_access(periph_addr(UART_SLAVE, UART_DIV), data_t'(div), 4'hf, rd);
      bus_access(periph_addr(UART_SLAVE, UART_DIV), '0, 4'h0, rd);
      check_word("uart div", rd, data_t'(div));
      for (int i = 0; i < N_BYTES; i++) begin
         tx_b = uart_byte_t'($urandom);
         wait_status(0, 1'b0);
         bus_access(periph_addr(UART_SLAVE, UART_TXDATA), data_t'(tx_b), 4'h1, rd);
         wait_status(1, 1'b1);
         bus_access(periph_addr(UART_SLAVE, UART_STATUS), '0, 4'h0, rd);
         check_bit("rx_valid", rd[1], 1'b1);
         bus_access(periph_addr(UART_SLAVE, UART_RXDATA), '0, 4'h0, rd);
         check_byte("rx_byte", uart_byte_t'(rd[7:0]), tx_b);
         bus_access(periph_addr(UART_SLAVE, UART_STATUS), '0, 4'h0, rd);
         check_bit("rx_valid", rd[1], 1'b0);
      end
      finish_test(5, "uart loopback");

      // frame must stall while cts is high
      @(posedge clk);
      uart_cts <= 1'b1;
      wait_status(0, 1'b0);
      tx_b = uart_byte_t'($urandom);
      bus_access(periph_addr(UART_SLAVE, UART_TXDATA), data_t'(tx_b), 4'h1, rd);
      txd_low = 1'b0;
      repeat (20 * div) begin
         @(posedge clk);
         if (uart_txd !== 1'b1) begin
            txd_low = 1'b1;
         end
      end
      check_bit("uart_txd low", txd_low, 1'b0);
      bus_access(periph_addr(UART_SLAVE, UART_STATUS), '0, 4'h0, rd);
      check_bit("rx_valid", rd[1], 1'b0);
      check_bit("uart_rts", uart_rts, 1'b1);
      uart_cts <= 1'b0;
      wait_status(1, 1'b1);
      @(negedge clk);
      check_bit("uart_rts", uart_rts, 1'b0);
      bus_access(periph_addr(UART_SLAVE, UART_RXDATA), '0, 4'h0, rd);
      check_byte("rx_byte", uart_byte_t'(rd[7:0]), tx_b);
      @(negedge clk);
      check_bit("uart_rts", uart_rts, 1'b1);
      finish_test(6, "uart flow control");

      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/soc_pkg.sv
verilog/uart_pkg.sv
verilog/int_mem.sv
verilog/periph_intercon.sv
verilog/uart_regs.sv
verilog/uart_core.sv
verilog/rst_ctr.sv
verilog/system.sv
bench/tb_system.sv

// ==== Bender.yml ====
package:
  name: system

sources:
  - files:
      - verilog/soc_pkg.sv
      - verilog/uart_pkg.sv
      - verilog/int_mem.sv
      - verilog/periph_intercon.sv
      - verilog/uart_regs.sv
      - verilog/uart_core.sv
      - verilog/rst_ctr.sv
      - verilog/system.sv
  - target: test
    files:
      - bench/tb_system.sv
